// File: src/pdp8_pkg.sv
`default_nettype none

package pdp8_pkg;

    localparam int word_w    = 12;      // Machine word
    localparam int mem_depth = 4096;    // 4K core
    localparam int offset_w  = 7;       // Page offset field of a memory reference
    localparam int eae_cnt_w = 5;       // EAE shift counter

    localparam logic [word_w-1:0] int_vector = '0;  // Return address slot

    // Major states of the sequencer
    typedef enum logic [4:0] {
        F0, FW, F1, F2, F3,             // Fetch
        D0, DW, D1, D2, D3,             // Defer
        E0, EW, E1, E2, E3,             // Execute
        H0, HW, H1, H2, H3,             // Halt and panel
        EAE0, EAE1
    } major_state_e;

    typedef enum logic [3:0] {
        OP_AND,
        OP_TAD,
        OP_ISZ,
        OP_DCA,
        OP_JMS,
        OP_JMP,
        OP_IOT,
        OP_OPR1,
        OP_OPR2,
        OP_EAE_SHL,
        OP_EAE_LSR,
        OP_NOP
    } opcode_e;

    typedef struct packed {
        opcode_e              op;
        logic                 is_mem_ref;       // Needs an execute cycle
        logic                 defer;            // Indirect bit
        logic                 is_halt;
        logic                 is_ion;
        logic                 is_iof;
        logic                 is_eae;
        logic                 is_jmp_direct;
        logic                 is_jmp_indirect;
        logic                 cur_page;         // Page bit of the address field
        logic [offset_w-1:0]  offset;
    } decoded_t;

    typedef struct packed {
        logic [word_w-1:0] sr;                  // Switch register
        logic              halt;
        logic              cont;
        logic              single_step;
        logic              dep;
    } panel_t;

endpackage

`default_nettype wire

// File: src/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import pdp8_pkg::*;
(
    input  wire logic [word_w-1:0] ir,
    output decoded_t               dec
);

    logic mem_field;

    assign mem_field = (ir[11:9] < 3'd6);   // Opcodes 0 to 5 carry an address

    always_comb
    begin
        dec    = '0;
        dec.op = OP_NOP;
        casez (ir)
            12'b000?????????: dec.op = OP_AND;
            12'b001?????????: dec.op = OP_TAD;
            12'b010?????????: dec.op = OP_ISZ;
            12'b011?????????: dec.op = OP_DCA;
            12'b100?????????: dec.op = OP_JMS;
            12'b101?????????: dec.op = OP_JMP;
            12'b110?????????: dec.op = OP_IOT;
            12'b1110????????: dec.op = OP_OPR1;
            12'b1111???????0: dec.op = OP_OPR2;
            12'b1111??0?1011: dec.op = OP_EAE_SHL;  // 7413
            12'b1111??0?1111: dec.op = OP_EAE_LSR;  // 7417
            default:          dec.op = OP_NOP;      // Rest of group 3
        endcase

        dec.is_mem_ref = mem_field && (ir[11:9] != 3'd5);
        dec.defer      = mem_field && ir[8];
        dec.is_halt    = (dec.op == OP_OPR2) && ir[1];
        dec.is_ion     = (ir == 12'o6001);
        dec.is_iof     = (ir == 12'o6002);
        dec.is_eae     = (dec.op == OP_EAE_SHL) || (dec.op == OP_EAE_LSR);
        dec.is_jmp_direct   = (dec.op == OP_JMP) && !ir[8];
        dec.is_jmp_indirect = (dec.op == OP_JMP) && ir[8];
        dec.cur_page   = ir[7];
        dec.offset     = ir[offset_w-1:0];
    end

    // The sequencer sends an EAE code to EAE0, never through defer or execute
    always_comb
    begin
        assert final (!(dec.is_eae && (dec.is_mem_ref || dec.defer)))
            else $error("EAE code decoded as memory reference");
    end

endmodule

`default_nettype wire

// File: src/major_state_seq.sv
`timescale 1ns/1ps
`default_nettype none

module major_state_seq import pdp8_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  decoded_t    dec,
    input  panel_t      panel,
    input  wire logic   int_req,
    input  wire logic   int_ena,
    input  wire logic   eae_loop,
    output major_state_e state,
    output logic        int_in_prog
);

    logic step_ok;
    logic int_take;

    assign step_ok  = !panel.single_step || panel.cont;  // Single step gate
    assign int_take = int_req && int_ena;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= H0;
            int_in_prog <= 1'b0;
        end
        else
        begin
            case (state)
                F0:
                begin
                    int_in_prog <= 1'b0;
                    if (step_ok)
                        state <= FW;
                end
                FW: state <= F1;
                F1: state <= F2;
                F2:
                begin
                    if (dec.is_eae)
                        state <= EAE0;
                    else
                        state <= F3;
                end
                F3:
                begin
                    if (dec.is_mem_ref || dec.is_jmp_indirect)
                        state <= dec.defer ? D0 : E0;
                    else if (panel.halt || dec.is_halt)
                        state <= H0;
                    else if (int_take && !dec.is_iof)   // IOF wins over a pending request
                    begin
                        int_in_prog <= 1'b1;
                        state       <= E0;
                    end
                    else
                        state <= F0;
                end

                D0:
                begin
                    if (step_ok)
                        state <= DW;
                end
                DW: state <= D1;
                D1: state <= D2;
                D2: state <= D3;
                D3:
                begin
                    if (!dec.is_jmp_indirect)
                        state <= E0;
                    else if (int_take)          // JMP I finishes here
                    begin
                        int_in_prog <= 1'b1;
                        state       <= E0;
                    end
                    else if (panel.halt)
                        state <= H0;
                    else
                        state <= F0;
                end

                E0:
                begin
                    if (step_ok)
                        state <= EW;
                end
                EW: state <= E1;
                E1: state <= E2;
                E2: state <= E3;
                E3:
                begin
                    if (panel.halt)
                        state <= H0;
                    else if (int_in_prog)       // Interrupt save just done
                        state <= F0;
                    else if (int_take)
                    begin
                        int_in_prog <= 1'b1;
                        state       <= E0;
                    end
                    else
                        state <= F0;
                end

                H0: state <= HW;
                HW:
                begin
                    if (panel.dep && !panel.cont)
                        state <= H1;            // Deposit
                    else if (panel.cont)
                        state <= panel.dep ? H0 : F0;  // Load address or continue
                end
                H1: state <= H2;
                H2: state <= H3;
                H3: state <= H0;

                EAE0: state <= EAE1;
                EAE1:
                begin
                    if (!eae_loop)
                        state <= F3;
                end
                default: state <= H0;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {[F0:EAE1]});

    a_int_entry: assert property (@(posedge clk) disable iff (reset)
        $rose(int_in_prog) |-> state == E0);

endmodule

`default_nettype wire

// File: src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import pdp8_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  major_state_e            state,
    input  wire logic               int_in_prog,
    input  decoded_t                dec,
    input  panel_t                  panel,
    input  wire logic [word_w-1:0]  mem_rdata,
    output logic [word_w-1:0]       ir,
    output logic [word_w-1:0]       ac,
    output logic [word_w-1:0]       pc,
    output logic                    link,
    output logic [word_w-1:0]       mem_addr,
    output logic [word_w-1:0]       mem_wdata,
    output logic                    mem_we,
    output logic                    eae_loop,
    output logic                    int_ena,
    output logic                    run
);

    logic [word_w-1:0]    ma;
    logic [word_w-1:0]    mq;
    logic [eae_cnt_w-1:0] sc;
    logic [word_w-1:0]    pc_prev;
    logic [word_w-1:0]    ea;
    logic [word_w-1:0]    isz_val;
    logic [word_w:0]      tad_sum;
    logic [word_w-1:0]    g1_ac;
    logic                 g1_link;
    logic                 g2_skip;

    assign pc_prev  = pc - 12'd1;           // Address of the current instruction
    assign ea       = dec.cur_page ? {pc_prev[word_w-1:offset_w], dec.offset}
                                   : {{(word_w-offset_w){1'b0}}, dec.offset};
    assign isz_val  = mem_rdata + 12'd1;
    assign tad_sum  = {1'b0, ac} + {1'b0, mem_rdata};
    assign mem_addr = ma;
    assign eae_loop = (sc != '0);
    assign run      = !(state inside {H0, HW, H1, H2, H3});

    // Group 1 microcode: clear, complement, increment, rotate
    always_comb
    begin
        g1_ac   = ac;
        g1_link = link;
        if (ir[7])
            g1_ac = '0;
        if (ir[6])
            g1_link = 1'b0;
        if (ir[5])
            g1_ac = ~g1_ac;
        if (ir[4])
            g1_link = ~g1_link;
        if (ir[0])
            {g1_link, g1_ac} = {g1_link, g1_ac} + 13'd1;
        if (ir[2])
            {g1_link, g1_ac} = {g1_ac, g1_link};                    // RAL
        else if (ir[3])
            {g1_link, g1_ac} = {g1_ac[0], g1_link, g1_ac[11:1]};    // RAR
    end

    assign g2_skip = ((ir[6] && ac[11]) || (ir[5] && (ac == '0)) || (ir[4] && link)) ^ ir[3];

    always_comb
    begin
        mem_we    = 1'b0;
        mem_wdata = ac;
        if (state == H1)
        begin
            mem_we    = 1'b1;
            mem_wdata = panel.sr;
        end
        else if (state == E3)
        begin
            if (int_in_prog)
            begin
                mem_we    = 1'b1;
                mem_wdata = pc;                 // Return address
            end
            else
            begin
                case (dec.op)
                    OP_ISZ:
                    begin
                        mem_we    = 1'b1;
                        mem_wdata = isz_val;
                    end
                    OP_DCA: mem_we = 1'b1;
                    OP_JMS:
                    begin
                        mem_we    = 1'b1;
                        mem_wdata = pc;
                    end
                    default: mem_we = 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ir <= '0;
            ac <= '0;
            pc <= '0;
            link <= 1'b0;
            ma <= '0;
            mq <= '0;
            sc <= '0;
            int_ena <= 1'b0;
        end
        else
        begin
            case (state)
                F0: ma <= pc;
                F1:
                begin
                    ir <= mem_rdata;
                    pc <= pc + 12'd1;
                    ma <= pc + 12'd1;           // EAE count word is read in F2
                end
                F3:
                begin
                    if (dec.is_jmp_direct)
                        pc <= ea;
                    else if (dec.is_mem_ref && !dec.defer)
                        ma <= ea;
                    else if (dec.op == OP_OPR1)
                    begin
                        ac   <= g1_ac;
                        link <= g1_link;
                    end
                    else if (dec.op == OP_OPR2)
                    begin
                        if (g2_skip)
                            pc <= pc + 12'd1;
                        if (ir[7])
                            ac <= '0;
                    end
                    else if (dec.is_ion)
                        int_ena <= 1'b1;
                    else if (dec.is_iof)
                        int_ena <= 1'b0;
                end
                D0: ma <= ea;
                D2: ma <= mem_rdata;            // Pointer becomes the address
                D3:
                begin
                    if (dec.is_jmp_indirect)
                        pc <= ma;
                end
                E0:
                begin
                    if (int_in_prog)
                        ma <= int_vector;
                end
                E3:
                begin
                    if (int_in_prog)
                    begin
                        pc      <= int_vector + 12'd1;
                        int_ena <= 1'b0;
                    end
                    else
                    begin
                        case (dec.op)
                            OP_AND: ac <= ac & mem_rdata;
                            OP_TAD:
                            begin
                                ac   <= tad_sum[word_w-1:0];
                                link <= link ^ tad_sum[word_w];
                            end
                            OP_ISZ:
                            begin
                                if (isz_val == '0)
                                    pc <= pc + 12'd1;
                            end
                            OP_DCA: ac <= '0;
                            OP_JMS: pc <= ma + 12'd1;
                            default: ;
                        endcase
                    end
                end
                H0: ma <= pc;
                HW:
                begin
                    if (panel.cont && panel.dep)
                        pc <= panel.sr;         // Load address
                end
                H3: pc <= pc + 12'd1;
                EAE0:
                begin
                    sc <= mem_rdata[eae_cnt_w-1:0];
                    pc <= pc + 12'd1;           // Step over the count word
                end
                EAE1:
                begin
                    if (sc != '0)
                    begin
                        sc <= sc - 1'b1;
                        if (dec.op == OP_EAE_SHL)
                            {link, ac, mq} <= {ac, mq, 1'b0};
                        else
                        begin
                            {ac, mq} <= {1'b0, ac, mq[word_w-1:1]};
                            link     <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module store_unit import pdp8_pkg::*;
(
    input  wire logic               clk,
    input  wire logic [word_w-1:0]  mem_addr,
    input  wire logic [word_w-1:0]  mem_wdata,
    input  wire logic               mem_we,
    output logic [word_w-1:0]       mem_rdata
);

    logic [word_w-1:0] mem [mem_depth];    // Core array

    always_ff @(posedge clk)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];         // Old data on a write cycle
    end

    a_addr_known: assert property (@(posedge clk)
        mem_we |-> !$isunknown(mem_addr));

endmodule

`default_nettype wire

// File: src/pdp8_top.sv
`timescale 1ns/1ps
`default_nettype none

module pdp8_top import pdp8_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,
    input  panel_t            panel,
    input  wire logic         int_req,
    output logic [word_w-1:0] ac,
    output logic              link,
    output logic [word_w-1:0] pc,
    output logic              run,
    output logic              int_in_prog,
    output major_state_e      state
);

    decoded_t          dec;
    logic [word_w-1:0] ir;
    logic [word_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic [word_w-1:0] mem_rdata;
    logic              mem_we;
    logic              eae_loop;
    logic              int_ena;

    instr_decode u_decode
    (
        .ir  (ir),
        .dec (dec)
    );

    major_state_seq u_seq
    (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .panel       (panel),
        .int_req     (int_req),
        .int_ena     (int_ena),
        .eae_loop    (eae_loop),
        .state       (state),
        .int_in_prog (int_in_prog)
    );

    execute_unit u_exec
    (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .int_in_prog (int_in_prog),
        .dec         (dec),
        .panel       (panel),
        .mem_rdata   (mem_rdata),
        .ir          (ir),
        .ac          (ac),
        .pc          (pc),
        .link        (link),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .eae_loop    (eae_loop),
        .int_ena     (int_ena),
        .run         (run)
    );

    store_unit u_store
    (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verif/pdp8_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pdp8_tb import pdp8_pkg::*;
();

    logic              clk = 1'b0;
    logic              reset;
    panel_t            panel;
    logic              int_req;
    logic [word_w-1:0] ac;
    logic [word_w-1:0] pc;
    logic              link;
    logic              run;
    logic              int_in_prog;
    major_state_e      state;

    int                errors;
    int                checks;
    logic [word_w-1:0] prog [$];        // Words for the next panel load

    pdp8_top uut
    (
        .clk         (clk),
        .reset       (reset),
        .panel       (panel),
        .int_req     (int_req),
        .ac          (ac),
        .link        (link),
        .pc          (pc),
        .run         (run),
        .int_in_prog (int_in_prog),
        .state       (state)
    );

    always #2 clk = ~clk;               // 4 ns period

    task automatic check(input string name, input logic [11:0] expected,
                         input logic [11:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_for_hw;
        int n = 0;
        @(negedge clk);
        while (state != HW && n < 100)
        begin
            @(negedge clk);
            n++;
        end
        if (state != HW)
        begin
            errors++;
            $display("Machine did not reach the panel wait state");
        end
    endtask

    task automatic pulse_cont;
        @(posedge clk);
        panel.cont <= 1'b1;
        @(posedge clk);
        panel.cont <= 1'b0;
    endtask

    task automatic load_address(input logic [11:0] addr);
        wait_for_hw();
        @(posedge clk);
        panel.sr   <= addr;
        panel.dep  <= 1'b1;
        panel.cont <= 1'b1;             // Cont with dep loads PC
        @(posedge clk);
        panel.dep  <= 1'b0;
        panel.cont <= 1'b0;
    endtask

    task automatic deposit_word(input logic [11:0] value);
        wait_for_hw();
        @(posedge clk);
        panel.sr  <= value;
        panel.dep <= 1'b1;
        @(posedge clk);
        panel.dep <= 1'b0;
    endtask

    task automatic load_block(input logic [11:0] start);
        load_address(start);
        foreach (prog[i])
            deposit_word(prog[i]);
    endtask

    task automatic stop_machine;
        int n = 0;
        @(posedge clk);
        panel.single_step <= 1'b0;
        panel.halt        <= 1'b1;
        @(negedge clk);
        while (run && n < 200)
        begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        panel.halt <= 1'b0;
        if (run)
        begin
            errors++;
            $display("Machine could not be stopped with the halt switch");
        end
    endtask

    task automatic wait_for_halt(input int limit);
        int n = 0;
        @(negedge clk);
        while (run && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (run)
        begin
            errors++;
            $display("Program did not halt within %0d cycles", limit);
            stop_machine();
        end
    endtask

    task automatic resume_program(input int limit);
        wait_for_hw();
        pulse_cont();
        wait_for_halt(limit);
    endtask

    task automatic run_from(input logic [11:0] start, input int limit);
        load_address(start);
        resume_program(limit);
    endtask

    // One cont pulse from a parked F0 runs one operate instruction
    task automatic step_one_instruction(input logic [11:0] next_pc);
        int cycles;
        pulse_cont();
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (state != F0 && cycles < 20);
        check("step_cycles", 12'd5, 12'(cycles));
        check("pc", next_pc, pc);
    endtask

    task automatic test_reset_state;
        @(negedge clk);
        check("state", 12'(H0), 12'(state));
        check("run", 12'd0, 12'(run));
        check("int_in_prog", 12'd0, 12'(int_in_prog));
        check("ac", 12'd0, ac);
        check("pc", 12'd0, pc);
    endtask

    task automatic test_arithmetic;
        logic [11:0] a;
        logic [11:0] b;
        logic [12:0] sum;
        a   = 12'($urandom);
        b   = 12'($urandom);
        sum = {1'b0, a} + {1'b0, b};    // Carry out lands in bit 12
        prog = '{a, b, 12'o0000};
        load_block(12'o100);
        prog = '{12'o7300, 12'o1100, 12'o1101, 12'o3102, 12'o1102, 12'o7402};
        load_block(12'o20);
        run_from(12'o20, 200);
        check("ac", sum[11:0], ac);
        check("link", 12'(sum[12]), 12'(link));
        check("pc", 12'o26, pc);
    endtask

    task automatic test_control_flow;
        prog = '{12'o0000, 12'o7001, 12'o5460};     // Return slot, IAC, JMP I 60
        load_block(12'o60);
        prog = '{12'o7773};                         // Minus 5
        load_block(12'o110);
        prog = '{12'o7300, 12'o4060, 12'o2110, 12'o5041, 12'o7402};
        load_block(12'o40);
        run_from(12'o40, 1000);
        check("ac", 12'd5, ac);
        check("link", 12'd0, 12'(link));
        check("pc", 12'o45, pc);
    endtask

    task automatic test_operate;
        logic [11:0] r;
        logic [11:0] rot_ac;
        logic        rot_link;
        r = 12'($urandom);
        prog = '{r};
        load_block(12'o177);
        prog = '{12'o7300, 12'o7240, 12'o7402, 12'o7001, 12'o7402,
                 12'o7300, 12'o1177, 12'o7004, 12'o7402, 12'o7010, 12'o7402,
                 12'o7200, 12'o7440, 12'o7402, 12'o7500, 12'o7402,
                 12'o7300, 12'o1177, 12'o7041, 12'o7402};
        load_block(12'o120);
        run_from(12'o120, 200);                     // CLA CMA
        check("ac", 12'o7777, ac);
        check("link", 12'd0, 12'(link));
        resume_program(200);                        // IAC wraps into the link
        check("ac", 12'o0000, ac);
        check("link", 12'd1, 12'(link));
        resume_program(200);
        rot_link = r[11];                           // RAL with link clear
        rot_ac   = {r[10:0], 1'b0};
        check("ac", rot_ac, ac);
        check("link", 12'(rot_link), 12'(link));
        resume_program(200);
        check("ac", {rot_link, rot_ac[11:1]}, ac);  // RAR
        check("link", 12'(rot_ac[0]), 12'(link));
        resume_program(200);
        check("pc", 12'o140, pc);                   // Past the skipped HLT only
        resume_program(200);
        check("ac", ~r + 12'd1, ac);                // Complement before increment
        check("link", 12'(r == 12'd0), 12'(link));
        check("pc", 12'o144, pc);
    endtask

    task automatic test_eae_shifts;
        logic [11:0] v;
        logic [11:0] n;
        logic [23:0] acmq;
        logic        shl_link;
        v = 12'($urandom);
        n = 12'(1 + ($urandom % 12));
        prog = '{v};
        load_block(12'o176);
        prog = '{12'o7320, 12'o1176, 12'o7417, n, 12'o7402,     // CLA CLL CML sets the link
                 12'o7413, 12'o0003, 12'o7402};
        load_block(12'o200);
        run_from(12'o200, 200);
        acmq = {v, 12'd0} >> n;                     // MQ starts at 0
        check("ac", acmq[23:12], ac);
        check("link", 12'd0, 12'(link));
        resume_program(200);
        shl_link = acmq[21];                        // Last bit out of AC
        acmq     = acmq << 3;
        check("ac", acmq[23:12], ac);
        check("link", 12'(shl_link), 12'(link));
        check("pc", 12'o210, pc);
    endtask

    task automatic test_interrupt_and_step;
        int n = 0;
        prog = '{12'o0000, 12'o1000, 12'o7402};     // Save slot, TAD 0, HLT
        load_block(12'o0);
        prog = '{12'o7300, 12'o6001, 12'o5302};     // CLA CLL, ION, JMP .
        load_block(12'o300);
        load_address(12'o300);
        wait_for_hw();
        pulse_cont();
        repeat (20) @(posedge clk);
        int_req <= 1'b1;
        @(negedge clk);
        while (!int_in_prog && n < 50)
        begin
            @(negedge clk);
            n++;
        end
        if (!int_in_prog)
        begin
            errors++;
            $display("Interrupt request was not taken");
        end
        wait_for_halt(200);
        @(posedge clk);
        int_req <= 1'b0;
        check("ac", 12'o302, ac);                   // Return address of the loop
        check("pc", 12'o3, pc);

        load_address(12'o300);
        @(posedge clk);
        panel.single_step <= 1'b1;
        wait_for_hw();
        pulse_cont();                               // Parks in F0
        step_one_instruction(12'o301);
        step_one_instruction(12'o302);
        stop_machine();
    endtask

    // Programs take under 1500 cycles at 4 ns
    initial
    begin
        #20000;
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        void'($urandom(6357));
        panel   = '0;
        int_req = 1'b0;
        reset   = 1'b1;
        errors  = 0;
        checks  = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_arithmetic();
        test_control_flow();
        test_operate();
        test_eae_shifts();
        test_interrupt_and_step();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/pdp8_pkg.sv
src/instr_decode.sv
src/major_state_seq.sv
src/execute_unit.sv
src/store_unit.sv
src/pdp8_top.sv
verif/pdp8_tb.sv
